// File: logic/isaPkg.sv
// encodings cover only the supported subset; loads, stores, halt and rti decode as unknown
package isaPkg;

   // data and pc width
   localparam int dataWidth = 16;
   // architectural registers
   localparam int numRegs = 8;
   localparam int regIdxWidth = $clog2(numRegs);
   // jal and jalr write their return address here
   localparam logic [regIdxWidth-1:0] linkReg = 3'd7;

   // instruction field positions
   localparam int opHi = 15;
   localparam int opLo = 11;
   localparam int rsHi = 10;
   localparam int rsLo = 8;
   // rt field, which is also rd for the five-bit immediate forms
   localparam int rtHi = 7;
   localparam int rtLo = 5;
   // rd of the register forms
   localparam int rdHi = 4;
   localparam int rdLo = 2;

   // major opcodes, bits 15 to 11
   typedef enum logic [4:0] {
      opJ     = 5'b00100,
      opJr    = 5'b00101,
      opJal   = 5'b00110,
      opJalr  = 5'b00111,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opBltz  = 5'b01110,
      opBgez  = 5'b01111,
      opSlbi  = 5'b10010,
      opRoli  = 5'b10100,
      opSlli  = 5'b10101,
      opRori  = 5'b10110,
      opSrli  = 5'b10111,
      opLbi   = 5'b11000,
      opBtr   = 5'b11001,
      opShift = 5'b11010,
      opArith = 5'b11011,
      opSeq   = 5'b11100,
      opSlt   = 5'b11101,
      opSle   = 5'b11110,
      opSco   = 5'b11111
   } opcodeE;

   // bits 1:0 of the register forms
   // the shift group reuses the same codes as rol, sll, ror, srl
   typedef enum logic [1:0] {
      functAdd  = 2'b00,
      functSub  = 2'b01,
      functXor  = 2'b10,
      functAndn = 2'b11
   } aluFunctE;

endpackage

// File: logic/corePkg.sv
// types of the core itself; packet widths follow isaPkg::dataWidth and are fixed at 16 bits
package corePkg;

   // operations of the alu
   // aluAndn is the and unit, the complement comes from invB
   typedef enum logic [2:0] {
      aluAdd,
      aluXor,
      aluAndn,
      aluRol,
      aluSll,
      aluRor,
      aluSrl
   } aluOpE;

   // which compare, if any, produces the write value
   typedef enum logic [2:0] {
      setNone,
      setSeq,
      setSlt,
      setSle,
      setSco
   } setKindE;

   // condition tested on rs for the conditional branches
   typedef enum logic [1:0] {
      brEqz,
      brNez,
      brLtz,
      brGez
   } brCondE;

   // decoded control word
   typedef struct packed {
      aluOpE aluOp;
      logic invA;
      logic invB;
      // operand b from the immediate
      logic immSel;
      // operand a is rs shifted up one byte
      logic slbi;
      // operand a forced to zero, used by lbi
      logic clrA;
      setKindE setKind;
      logic btr;
      logic branch;
      brCondE brCond;
      logic jump;
      logic jumpReg;
      logic link;
      logic writeEn;
      logic [isaPkg::regIdxWidth-1:0] dest;
   } ctrlS;

   // host to core, 32 bits
   typedef struct packed {
      logic [isaPkg::dataWidth-1:0] word;
      logic [isaPkg::dataWidth-1:0] pc;
   } issueS;

   // core to host, 34 bits
   typedef struct packed {
      logic [isaPkg::dataWidth-1:0] writeData;
      logic [isaPkg::dataWidth-1:0] newPc;
      logic ofl;
      logic write;
   } resultS;

   typedef enum logic [1:0] {
      hsIdle,
      hsExec,
      hsDone
   } hsStateE;

endpackage

// File: logic/alu.sv
// shift and rotate amounts use only the low log2(dataWidth) bits of b; ofl is valid for add only
`timescale 1ns/1ps

module alu #(
   parameter int dataWidth = 16
) (
   input  logic [dataWidth-1:0] a,
   input  logic [dataWidth-1:0] b,
   input  corePkg::aluOpE op,
   input  logic invA,
   input  logic invB,
   output logic [dataWidth-1:0] sum,
   output logic carry,
   output logic zero,
   output logic ofl
);

   localparam int shWidth = $clog2(dataWidth);

   logic [dataWidth-1:0] aIn;
   logic [dataWidth-1:0] bIn;
   logic cin;
   logic [dataWidth:0] addFull;
   logic [shWidth-1:0] amt;

   // inverted operand plus carry in gives the two's complement
   assign aIn = invA ? ~a : a;
   assign bIn = invB ? ~b : b;
   assign cin = invA | invB;

   assign addFull = {1'b0, aIn} + {1'b0, bIn} + {{dataWidth{1'b0}}, cin};
   assign amt = b[shWidth-1:0];

   always_comb begin
      case (op)
         corePkg::aluAdd: sum = addFull[dataWidth-1:0];
         corePkg::aluXor: sum = aIn ^ bIn;
         // complement of b is already in bIn
         corePkg::aluAndn: sum = aIn & bIn;
         corePkg::aluRol: sum = (aIn << amt) | (aIn >> (dataWidth - amt));
         corePkg::aluSll: sum = aIn << amt;
         corePkg::aluRor: sum = (aIn >> amt) | (aIn << (dataWidth - amt));
         corePkg::aluSrl: sum = aIn >> amt;
         default: sum = addFull[dataWidth-1:0];
      endcase
   end

   assign carry = addFull[dataWidth];
   assign zero = (sum == '0);

   // like-signed inputs with a result of the other sign
   assign ofl = (op == corePkg::aluAdd)
              & (aIn[dataWidth-1] == bIn[dataWidth-1])
              & (addFull[dataWidth-1] != aIn[dataWidth-1]);

endmodule

// File: logic/execute.sv
// purely combinational; pc steps by 2 and branch and jump offsets are in bytes from pc+2
`timescale 1ns/1ps

module execute #(
   parameter int dataWidth = 16
) (
   input  corePkg::ctrlS ctrl,
   input  logic [dataWidth-1:0] rsData,
   input  logic [dataWidth-1:0] rtData,
   input  logic [dataWidth-1:0] imm,
   input  logic [dataWidth-1:0] pc,
   output logic [dataWidth-1:0] writeData,
   output logic [dataWidth-1:0] newPc,
   output logic ofl
);

   localparam logic [dataWidth-1:0] pcStep = 2;

   logic [dataWidth-1:0] opA;
   logic [dataWidth-1:0] opB;
   logic [dataWidth-1:0] aluSum;
   logic aluCarry;
   logic aluZero;
   logic aluOfl;
   logic [dataWidth-1:0] setVal;
   logic [dataWidth-1:0] revRs;
   logic [dataWidth-1:0] pcInc;
   logic [dataWidth-1:0] target;
   logic taken;

   // lbi clears a so the sum is the immediate
   // slbi adds the byte into the zero low byte of the shifted rs without carry
   assign opA = ctrl.clrA ? '0 : (ctrl.slbi ? (rsData << 8) : rsData);
   // branches pass rs through so zero and sign can be tested
   assign opB = ctrl.branch ? '0 : (ctrl.immSel ? imm : rtData);

   alu #(
      .dataWidth(dataWidth)
   ) uAlu (
      .a(opA),
      .b(opB),
      .op(ctrl.aluOp),
      .invA(ctrl.invA),
      .invB(ctrl.invB),
      .sum(aluSum),
      .carry(aluCarry),
      .zero(aluZero),
      .ofl(aluOfl)
   );

   // compares work on the raw register values
   always_comb begin
      setVal = '0;
      case (ctrl.setKind)
         corePkg::setSeq: setVal[0] = (rsData == rtData);
         corePkg::setSlt: setVal[0] = ($signed(rsData) < $signed(rtData));
         corePkg::setSle: setVal[0] = ($signed(rsData) <= $signed(rtData));
         // carry out of rs plus rt
         corePkg::setSco: setVal[0] = aluCarry;
         default: setVal[0] = 1'b0;
      endcase
   end

   always_comb begin
      for (int i = 0; i < dataWidth; i++) begin
         revRs[i] = rsData[dataWidth-1-i];
      end
   end

   assign pcInc = pc + pcStep;
   assign target = pcInc + imm;

   always_comb begin
      case (ctrl.brCond)
         corePkg::brEqz: taken = aluZero;
         corePkg::brNez: taken = ~aluZero;
         corePkg::brLtz: taken = aluSum[dataWidth-1];
         default: taken = ~aluSum[dataWidth-1];
      endcase
   end

   // priority is link value over compares over btr over the alu sum
   assign writeData = ctrl.link ? pcInc
                    : (ctrl.setKind != corePkg::setNone) ? setVal
                    : ctrl.btr ? revRs
                    : aluSum;

   assign newPc = ctrl.jumpReg ? aluSum
                : (ctrl.jump | (ctrl.branch & taken)) ? target
                : pcInc;

   // overflow only reported for arithmetic that writes the alu sum
   assign ofl = aluOfl & ~ctrl.jump & ~ctrl.branch & ~ctrl.btr
              & (ctrl.setKind == corePkg::setNone);

endmodule

// File: logic/instrDecode.sv
// unsupported opcodes decode to a no-op with no register write and pc+2
`timescale 1ns/1ps

module instrDecode (
   input  logic [15:0] instr,
   output corePkg::ctrlS ctrl,
   output logic [15:0] imm,
   output logic [2:0] rsIdx,
   output logic [2:0] rtIdx
);

   isaPkg::opcodeE op;
   isaPkg::aluFunctE funct;
   logic [2:0] rdIdx;

   // shift group code to alu op, same order for register and immediate forms
   function automatic corePkg::aluOpE shiftOp(input logic [1:0] code);
      case (code)
         2'b00: shiftOp = corePkg::aluRol;
         2'b01: shiftOp = corePkg::aluSll;
         2'b10: shiftOp = corePkg::aluRor;
         default: shiftOp = corePkg::aluSrl;
      endcase
   endfunction

   assign op = isaPkg::opcodeE'(instr[isaPkg::opHi:isaPkg::opLo]);
   assign funct = isaPkg::aluFunctE'(instr[1:0]);
   assign rsIdx = instr[isaPkg::rsHi:isaPkg::rsLo];
   assign rtIdx = instr[isaPkg::rtHi:isaPkg::rtLo];
   assign rdIdx = instr[isaPkg::rdHi:isaPkg::rdLo];

   always_comb begin
      ctrl = '0;
      ctrl.aluOp = corePkg::aluAdd;
      ctrl.setKind = corePkg::setNone;
      ctrl.brCond = corePkg::brEqz;
      ctrl.dest = rdIdx;
      // five-bit signed immediate unless an opcode says otherwise
      imm = {{11{instr[4]}}, instr[4:0]};
      case (op)
         isaPkg::opArith: begin
            ctrl.writeEn = 1'b1;
            case (funct)
               // rt minus rs
               isaPkg::functSub: ctrl.invA = 1'b1;
               isaPkg::functXor: ctrl.aluOp = corePkg::aluXor;
               isaPkg::functAndn: begin
                  ctrl.aluOp = corePkg::aluAndn;
                  ctrl.invB = 1'b1;
               end
               default: ctrl.aluOp = corePkg::aluAdd;
            endcase
         end
         isaPkg::opShift: begin
            ctrl.writeEn = 1'b1;
            ctrl.aluOp = shiftOp(funct);
         end
         isaPkg::opAddi, isaPkg::opSubi, isaPkg::opXori, isaPkg::opAndni: begin
            ctrl.writeEn = 1'b1;
            ctrl.immSel = 1'b1;
            ctrl.dest = rtIdx;
            // subi is imm minus rs
            ctrl.invA = (op == isaPkg::opSubi);
            if (op == isaPkg::opXori || op == isaPkg::opAndni) begin
               // logic immediates are zero extended
               imm = {11'b0, instr[4:0]};
               ctrl.aluOp = (op == isaPkg::opXori) ? corePkg::aluXor : corePkg::aluAndn;
               ctrl.invB = (op == isaPkg::opAndni);
            end
         end
         isaPkg::opRoli, isaPkg::opSlli, isaPkg::opRori, isaPkg::opSrli: begin
            ctrl.writeEn = 1'b1;
            ctrl.immSel = 1'b1;
            ctrl.dest = rtIdx;
            ctrl.aluOp = shiftOp(instr[12:11]);
            imm = {11'b0, instr[4:0]};
         end
         isaPkg::opSeq: begin
            ctrl.writeEn = 1'b1;
            ctrl.setKind = corePkg::setSeq;
         end
         isaPkg::opSlt: begin
            ctrl.writeEn = 1'b1;
            ctrl.setKind = corePkg::setSlt;
         end
         isaPkg::opSle: begin
            ctrl.writeEn = 1'b1;
            ctrl.setKind = corePkg::setSle;
         end
         isaPkg::opSco: begin
            ctrl.writeEn = 1'b1;
            ctrl.setKind = corePkg::setSco;
         end
         isaPkg::opBtr: begin
            ctrl.writeEn = 1'b1;
            ctrl.btr = 1'b1;
         end
         isaPkg::opLbi, isaPkg::opSlbi: begin
            ctrl.writeEn = 1'b1;
            ctrl.immSel = 1'b1;
            ctrl.dest = rsIdx;
            ctrl.clrA = (op == isaPkg::opLbi);
            ctrl.slbi = (op == isaPkg::opSlbi);
            // lbi sign extends, slbi fills the low byte
            imm = (op == isaPkg::opLbi) ? {{8{instr[7]}}, instr[7:0]} : {8'b0, instr[7:0]};
         end
         isaPkg::opBeqz, isaPkg::opBnez, isaPkg::opBltz, isaPkg::opBgez: begin
            ctrl.branch = 1'b1;
            // low opcode bits give the condition in brCondE order
            ctrl.brCond = corePkg::brCondE'(instr[12:11]);
            imm = {{8{instr[7]}}, instr[7:0]};
         end
         isaPkg::opJ, isaPkg::opJal: begin
            ctrl.jump = 1'b1;
            ctrl.link = (op == isaPkg::opJal);
            ctrl.writeEn = (op == isaPkg::opJal);
            ctrl.dest = isaPkg::linkReg;
            imm = {{5{instr[10]}}, instr[10:0]};
         end
         isaPkg::opJr, isaPkg::opJalr: begin
            // target is rs plus imm from the alu
            ctrl.jump = 1'b1;
            ctrl.jumpReg = 1'b1;
            ctrl.immSel = 1'b1;
            ctrl.link = (op == isaPkg::opJalr);
            ctrl.writeEn = (op == isaPkg::opJalr);
            ctrl.dest = isaPkg::linkReg;
            imm = {{8{instr[7]}}, instr[7:0]};
         end
         default: ctrl.writeEn = 1'b0;
      endcase
   end

endmodule

// File: logic/regFile.sv
// no bypass: a read in the write cycle sees the old value; every register is general, r0 too
`timescale 1ns/1ps

module regFile #(
   parameter int dataWidth = 16,
   parameter int numRegs = 8
) (
   input  logic clk,
   input  logic rstN,
   input  logic [$clog2(numRegs)-1:0] rsIdx,
   input  logic [$clog2(numRegs)-1:0] rtIdx,
   output logic [dataWidth-1:0] rsData,
   output logic [dataWidth-1:0] rtData,
   input  logic writeEn,
   input  logic [$clog2(numRegs)-1:0] writeIdx,
   input  logic [dataWidth-1:0] writeData
);

   logic [dataWidth-1:0] regs [numRegs];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeIdx] <= writeData;
      end
   end

   // two combinational read ports
   assign rsData = regs[rsIdx];
   assign rtData = regs[rtIdx];

endmodule

// File: logic/issueCtrl.sv
// host must keep req high until ack and raise it again only after ack falls
`timescale 1ns/1ps

module issueCtrl (
   input  logic clk,
   input  logic rstN,
   input  logic req,
   input  corePkg::issueS issue,
   output corePkg::issueS instr,
   input  corePkg::resultS exWrite,
   output logic writeEn,
   output logic ack,
   output corePkg::resultS result
);

   corePkg::hsStateE state;

   // handshake fsm, one exec cycle per instruction
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= corePkg::hsIdle;
         ack <= 1'b0;
         result <= '0;
      end else begin
         case (state)
            corePkg::hsIdle: begin
               if (req) state <= corePkg::hsExec;
            end
            corePkg::hsExec: begin
               // result and ack are registered together
               state <= corePkg::hsDone;
               result <= exWrite;
               ack <= 1'b1;
            end
            corePkg::hsDone: begin
               // held while the host keeps req high
               if (!req) begin
                  state <= corePkg::hsIdle;
                  ack <= 1'b0;
               end
            end
            default: state <= corePkg::hsIdle;
         endcase
      end
   end

   // instruction capture on the edge that sees req in idle
   always_ff @(posedge clk) begin
      if (state == corePkg::hsIdle && req) instr <= issue;
   end

   // single write strobe, only in exec
   assign writeEn = (state == corePkg::hsExec) & exWrite.write;

endmodule

// File: logic/execCore.sv
// single-issue core, no loads, stores or halt; ack follows two edges after req is sampled
`timescale 1ns/1ps

module execCore #(
   parameter int dataWidth = isaPkg::dataWidth,
   parameter int numRegs = isaPkg::numRegs
) (
   input  logic clk,
   input  logic rstN,
   input  logic req,
   input  corePkg::issueS issue,
   output logic ack,
   output corePkg::resultS result
);

   corePkg::issueS instr;
   corePkg::ctrlS ctrl;
   corePkg::resultS exWrite;
   logic [dataWidth-1:0] imm;
   logic [dataWidth-1:0] rsData;
   logic [dataWidth-1:0] rtData;
   logic [dataWidth-1:0] exData;
   logic [dataWidth-1:0] exPc;
   logic [$clog2(numRegs)-1:0] rsIdx;
   logic [$clog2(numRegs)-1:0] rtIdx;
   logic exOfl;
   logic writeEn;

   issueCtrl uIssue (
      .clk(clk), .rstN(rstN), .req(req), .issue(issue), .instr(instr),
      .exWrite(exWrite), .writeEn(writeEn), .ack(ack), .result(result)
   );

   instrDecode uDecode (
      .instr(instr.word), .ctrl(ctrl), .imm(imm), .rsIdx(rsIdx), .rtIdx(rtIdx)
   );

   regFile #(.dataWidth(dataWidth), .numRegs(numRegs)) uRegs (
      .clk(clk), .rstN(rstN), .rsIdx(rsIdx), .rtIdx(rtIdx), .rsData(rsData),
      .rtData(rtData), .writeEn(writeEn), .writeIdx(ctrl.dest), .writeData(exData)
   );

   execute #(.dataWidth(dataWidth)) uExec (
      .ctrl(ctrl), .rsData(rsData), .rtData(rtData), .imm(imm), .pc(instr.pc),
      .writeData(exData), .newPc(exPc), .ofl(exOfl)
   );

   // result packet from execute, write flag straight from decode
   assign exWrite = {exData, exPc, exOfl, ctrl.writeEn};

endmodule

// File: dv/execTests.svh
// directed tests; relies on the issue, compare and result helpers and pcNow of the testbench
`ifndef EXEC_TESTS_SVH
`define EXEC_TESTS_SVH

// instruction encoders in the field layout of the isa
function automatic logic [15:0] encReg(input isaPkg::opcodeE op, input logic [2:0] rs,
                                       input logic [2:0] rt, input logic [2:0] rd,
                                       input logic [1:0] fn);
   return {op, rs, rt, rd, fn};
endfunction

function automatic logic [15:0] encImm5(input isaPkg::opcodeE op, input logic [2:0] rs,
                                        input logic [2:0] rt, input logic [4:0] imm);
   return {op, rs, rt, imm};
endfunction

function automatic logic [15:0] encImm8(input isaPkg::opcodeE op, input logic [2:0] rs,
                                        input logic [7:0] imm);
   return {op, rs, imm};
endfunction

function automatic logic [15:0] encDisp(input isaPkg::opcodeE op, input logic [10:0] disp);
   return {op, disp};
endfunction

// reference models
function automatic logic [15:0] rotLeft(input logic [15:0] v, input int n);
   logic [15:0] r;
   r = v;
   repeat (n % 16) r = {r[14:0], r[15]};
   return r;
endfunction

function automatic logic [15:0] rotRight(input logic [15:0] v, input int n);
   logic [15:0] r;
   r = v;
   repeat (n % 16) r = {r[0], r[15:1]};
   return r;
endfunction

function automatic logic [15:0] reverseBits(input logic [15:0] v);
   logic [15:0] r;
   for (int i = 0; i < 16; i++) begin
      r[i] = v[15 - i];
   end
   return r;
endfunction

function automatic logic addOverflows(input logic [15:0] a, input logic [15:0] b);
   logic [15:0] s;
   s = a + b;
   return (a[15] == b[15]) && (s[15] != a[15]);
endfunction

// m minus s
function automatic logic subOverflows(input logic [15:0] m, input logic [15:0] s);
   logic [15:0] d;
   d = m - s;
   return (m[15] != s[15]) && (d[15] != m[15]);
endfunction

task automatic runAndCheck(input string name, input logic [15:0] word,
                           input corePkg::resultS exp, input corePkg::resultS care);
   corePkg::resultS res;
   issueInstr(word, 0, res);
   checkResult(name, res, exp, care);
endtask

// lbi with the high byte and then slbi with the low byte
task automatic loadReg(input logic [2:0] idx, input logic [15:0] value);
   runAndCheck("lbi", encImm8(isaPkg::opLbi, idx, value[15:8]),
               mkResult({{8{value[15]}}, value[15:8]}, pcNow + 16'd2, 1'b0, 1'b1), careAll);
   runAndCheck("slbi", encImm8(isaPkg::opSlbi, idx, value[7:0]),
               mkResult(value, pcNow + 16'd2, 1'b0, 1'b1), careAll);
endtask

// addi with zero immediate writes the register back unchanged
task automatic readBack(input string name, input logic [2:0] idx, input logic [15:0] expVal);
   runAndCheck(name, encImm5(isaPkg::opAddi, idx, idx, 5'd0),
               mkResult(expVal, pcNow + 16'd2, 1'b0, 1'b1), careAll);
endtask

task automatic testHandshake();
   corePkg::resultS res;
   logic [15:0] pc0;
   checkWord("ack", {15'b0, ack}, 16'd0);
   checkResult("resultAfterReset", result, '0, careAll);
   pc0 = pcNow;
   // addi r1 from r0 with req held three extra cycles
   issueInstr(encImm5(isaPkg::opAddi, 3'd0, 3'd1, 5'd0), 3, res);
   checkResult("addiR0", res, mkResult(16'h0000, pc0 + 16'd2, 1'b0, 1'b1), careAll);
endtask

// r3 from r1 and r2
task automatic regOp(input string name, input isaPkg::opcodeE op, input logic [1:0] fn,
                     input logic [15:0] expVal, input logic expOfl);
   runAndCheck(name, encReg(op, 3'd1, 3'd2, 3'd3, fn),
               mkResult(expVal, pcNow + 16'd2, expOfl, 1'b1), careAll);
   readBack({name, "ReadBack"}, 3'd3, expVal);
endtask

task automatic testRegOps();
   logic [15:0] a;
   logic [15:0] b;
   int amt;
   for (int iter = 0; iter < 6; iter++) begin
      a = 16'($urandom());
      b = 16'($urandom());
      // positive and negative signed overflow on add
      if (iter == 0) begin
         a = 16'h7fff;
         b = 16'h0001;
      end
      if (iter == 1) begin
         a = 16'h8000;
         b = 16'h8000;
      end
      amt = int'(b[3:0]);
      loadReg(3'd1, a);
      loadReg(3'd2, b);
      regOp("add", isaPkg::opArith, isaPkg::functAdd, a + b, addOverflows(a, b));
      // sub is rt minus rs
      regOp("sub", isaPkg::opArith, isaPkg::functSub, b - a, subOverflows(b, a));
      regOp("xor", isaPkg::opArith, isaPkg::functXor, a ^ b, 1'b0);
      regOp("andn", isaPkg::opArith, isaPkg::functAndn, a & ~b, 1'b0);
      regOp("rol", isaPkg::opShift, 2'b00, rotLeft(a, amt), 1'b0);
      regOp("sll", isaPkg::opShift, 2'b01, a << amt, 1'b0);
      regOp("ror", isaPkg::opShift, 2'b10, rotRight(a, amt), 1'b0);
      regOp("srl", isaPkg::opShift, 2'b11, a >> amt, 1'b0);
   end
endtask

// r4 from r1 and a five-bit immediate
task automatic immOp(input string name, input isaPkg::opcodeE op, input logic [4:0] imm,
                     input logic [15:0] expVal, input logic expOfl);
   runAndCheck(name, encImm5(op, 3'd1, 3'd4, imm),
               mkResult(expVal, pcNow + 16'd2, expOfl, 1'b1), careAll);
   readBack({name, "ReadBack"}, 3'd4, expVal);
endtask

task automatic testImmediates();
   logic [15:0] a;
   for (int iter = 0; iter < 2; iter++) begin
      // second pass sits near the positive limit
      a = (iter == 0) ? 16'($urandom()) : 16'h7ffe;
      loadReg(3'd1, a);
      immOp("addiNeg", isaPkg::opAddi, 5'b11101, a + 16'hfffd, addOverflows(a, 16'hfffd));
      immOp("addiPos", isaPkg::opAddi, 5'b01011, a + 16'h000b, addOverflows(a, 16'h000b));
      immOp("subi", isaPkg::opSubi, 5'b10010, 16'hfff2 - a, subOverflows(16'hfff2, a));
      // logic immediates are zero extended
      immOp("xori", isaPkg::opXori, 5'b10110, a ^ 16'h0016, 1'b0);
      immOp("andni", isaPkg::opAndni, 5'b11001, a & ~16'h0019, 1'b0);
      immOp("roli", isaPkg::opRoli, 5'd5, rotLeft(a, 5), 1'b0);
      immOp("slli", isaPkg::opSlli, 5'd3, a << 3, 1'b0);
      immOp("rori", isaPkg::opRori, 5'd11, rotRight(a, 11), 1'b0);
      immOp("srli", isaPkg::opSrli, 5'd15, a >> 15, 1'b0);
   end
endtask

task automatic cmpOp(input string name, input isaPkg::opcodeE op, input logic expBit);
   runAndCheck(name, encReg(op, 3'd1, 3'd2, 3'd5, 2'b00),
               mkResult({15'b0, expBit}, pcNow + 16'd2, 1'b0, 1'b1), careAll);
endtask

task automatic testCompares();
   logic [15:0] a;
   logic [15:0] b;
   logic [16:0] wide;
   for (int i = 0; i < 7; i++) begin
      a = 16'($urandom());
      b = 16'($urandom());
      case (i)
         2: b = a;
         3: begin
            a = 16'h8000;
            b = 16'h7fff;
         end
         4: begin
            a = 16'h7fff;
            b = 16'h8000;
         end
         5: begin
            a = 16'hffff;
            b = 16'h0001;
         end
         6: begin
            a = 16'h8000;
            b = 16'h8000;
         end
      endcase
      wide = {1'b0, a} + {1'b0, b};
      loadReg(3'd1, a);
      loadReg(3'd2, b);
      cmpOp("seq", isaPkg::opSeq, a == b);
      cmpOp("slt", isaPkg::opSlt, $signed(a) < $signed(b));
      cmpOp("sle", isaPkg::opSle, $signed(a) <= $signed(b));
      cmpOp("sco", isaPkg::opSco, wide[16]);
      // btr ignores rt and a live r2 in that field must not raise ofl
      runAndCheck("btr", encReg(isaPkg::opBtr, 3'd1, 3'd2, 3'd6, 2'b00),
                  mkResult(reverseBits(a), pcNow + 16'd2, 1'b0, 1'b1), careAll);
   end
endtask

task automatic branchCase(input string name, input isaPkg::opcodeE op, input logic [2:0] rs,
                          input logic [7:0] off, input logic expTaken);
   logic [15:0] npc;
   npc = expTaken ? pcNow + 16'd2 + {{8{off[7]}}, off} : pcNow + 16'd2;
   runAndCheck(name, encImm8(op, rs, off), mkResult(16'h0000, npc, 1'b0, 1'b0), careNoData);
endtask

task automatic testControlFlow();
   logic [15:0] link;
   // r1 zero, r2 negative, r3 positive, r4 jump base
   loadReg(3'd1, 16'h0000);
   loadReg(3'd2, 16'h8005);
   loadReg(3'd3, 16'h0042);
   loadReg(3'd4, 16'h1234);
   pcNow = 16'h0400;
   branchCase("beqzTaken", isaPkg::opBeqz, 3'd1, 8'hf0, 1'b1);
   branchCase("beqzNotTaken", isaPkg::opBeqz, 3'd3, 8'hf0, 1'b0);
   branchCase("bnezTaken", isaPkg::opBnez, 3'd3, 8'h0a, 1'b1);
   branchCase("bnezNotTaken", isaPkg::opBnez, 3'd1, 8'h0a, 1'b0);
   branchCase("bltzTaken", isaPkg::opBltz, 3'd2, 8'h7e, 1'b1);
   branchCase("bltzNotTaken", isaPkg::opBltz, 3'd3, 8'h7e, 1'b0);
   branchCase("bgezTaken", isaPkg::opBgez, 3'd3, 8'h80, 1'b1);
   branchCase("bgezZero", isaPkg::opBgez, 3'd1, 8'h06, 1'b1);
   branchCase("bgezNotTaken", isaPkg::opBgez, 3'd2, 8'h06, 1'b0);
   // displacement of minus six
   runAndCheck("j", encDisp(isaPkg::opJ, 11'h7fa),
               mkResult(16'h0000, pcNow + 16'd2 + 16'hfffa, 1'b0, 1'b0), careNoData);
   link = pcNow + 16'd2;
   runAndCheck("jal", encDisp(isaPkg::opJal, 11'h020),
               mkResult(link, link + 16'h0020, 1'b0, 1'b1), careAll);
   readBack("linkJal", isaPkg::linkReg, link);
   runAndCheck("jr", encImm8(isaPkg::opJr, 3'd3, 8'h04),
               mkResult(16'h0000, 16'h0046, 1'b0, 1'b0), careNoData);
   link = pcNow + 16'd2;
   runAndCheck("jalr", encImm8(isaPkg::opJalr, 3'd4, 8'hfe),
               mkResult(link, 16'h1232, 1'b0, 1'b1), careAll);
   readBack("linkJalr", isaPkg::linkReg, link);
endtask

`endif

// File: dv/tbExecCore.sv
// one instruction in flight at a time; stimulus on the falling edge; stops at the first mismatch
`timescale 1ns/1ps

module tbExecCore;

   localparam int clkPeriod = 20;
   localparam int resetCycles = 8;
   // upper bound on instructions the tests issue, sizes the watchdog
   localparam int maxInstr = 300;
   localparam int cyclesPerInstr = 12;
   // falling edges allowed between req and ack before giving up
   localparam int ackLimit = 8;
   localparam corePkg::resultS careAll = '1;
   // write value is ignored for instructions that write no register
   localparam corePkg::resultS careNoData = {16'h0000, 16'hffff, 1'b1, 1'b1};

   logic clk;
   logic rstN;
   logic req;
   corePkg::issueS issue;
   logic ack;
   corePkg::resultS result;
   // pc handed to the core with the next instruction
   logic [15:0] pcNow;
   int issuedCount;

   execCore #(
      .dataWidth(isaPkg::dataWidth),
      .numRegs(isaPkg::numRegs)
   ) i_execCore (
      .clk(clk),
      .rstN(rstN),
      .req(req),
      .issue(issue),
      .ack(ack),
      .result(result)
   );

   always #(clkPeriod / 2) clk = ~clk;

   task automatic failRun(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic checkWord(input string name, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         failRun($sformatf("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   // only bits set in care are compared
   task automatic checkResult(input string name, input corePkg::resultS got,
                              input corePkg::resultS exp, input corePkg::resultS care);
      if ((got & care) !== (exp & care)) begin
         failRun($sformatf("[ERROR] %s: got 0x%h expected 0x%h mask 0x%h",
                           name, got, exp, care));
      end
   endtask

   function automatic corePkg::resultS mkResult(input logic [15:0] data, input logic [15:0] npc,
                                                input logic ofl, input logic wr);
      corePkg::resultS r;
      r.writeData = data;
      r.newPc = npc;
      r.ofl = ofl;
      r.write = wr;
      return r;
   endfunction

   // full four-phase transfer, req held holdCycles extra edges once ack is seen
   task automatic issueInstr(input logic [15:0] word, input int holdCycles,
                             output corePkg::resultS res);
      int edges;
      if (issuedCount >= maxInstr) begin
         failRun("more instructions issued than the watchdog allows for");
      end
      issuedCount++;
      if (ack !== 1'b0) begin
         failRun("ack was still high when a new request started");
      end
      issue = {word, pcNow};
      req = 1'b1;
      edges = 0;
      while (ack !== 1'b1) begin
         @(negedge clk);
         edges++;
         if (edges > ackLimit) begin
            failRun("ack never rose after req was raised");
         end
      end
      // ack is due two rising edges after req is first sampled
      checkWord("ackLatency", 16'(edges), 16'd2);
      res = result;
      repeat (holdCycles) begin
         @(negedge clk);
         checkWord("ackHeld", {15'b0, ack}, 16'd1);
         checkResult("resultHeld", result, res, careAll);
      end
      req = 1'b0;
      @(negedge clk);
      checkWord("ackRelease", {15'b0, ack}, 16'd0);
      pcNow = res.newPc;
   endtask

   `include "execTests.svh"

   // generous per-instruction budget on top of reset
   initial begin
      #((maxInstr * cyclesPerInstr + resetCycles) * clkPeriod);
      failRun("watchdog expired, the core stopped answering the handshake");
   end

   initial begin
      void'($urandom(32'h15e));
      clk = 1'b0;
      rstN = 1'b0;
      req = 1'b0;
      issue = '0;
      pcNow = 16'h0100;
      issuedCount = 0;
      repeat (resetCycles) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;
      testHandshake();
      testRegOps();
      testImmediates();
      testCompares();
      testControlFlow();
      $display("test passed");
      $finish;
   end

endmodule

// File: files.f
+incdir+dv
logic/isaPkg.sv
logic/corePkg.sv
logic/alu.sv
logic/execute.sv
logic/instrDecode.sv
logic/regFile.sv
logic/issueCtrl.sv
logic/execCore.sv
dv/tbExecCore.sv

// File: run.sh
#!/bin/sh
# build and run the execCore testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tbExecCore -f files.f
./obj_dir/VtbExecCore 2>&1 | tee sim.log
if grep -qx "test passed" sim.log; then
   echo "simulation finished without errors"
else
   echo "simulation reported a failure, see sim.log"
   exit 1
fi
